// ==== Bender.yml ====
package:
  name: rs_alu

sources:
  - verilog/rs_pkg.sv
  - verilog/rs_queue_ctrl.sv
  - verilog/rs_entry_table.sv
  - verilog/rs_issue_select.sv
  - verilog/rs_alu.sv
  - target: test
    files:
      - dv/tb_rs_alu.sv

// ==== all.f ====
verilog/rs_pkg.sv
verilog/rs_queue_ctrl.sv
verilog/rs_entry_table.sv
verilog/rs_issue_select.sv
verilog/rs_alu.sv
dv/tb_rs_alu.sv

// ==== dv/tb_rs_alu.sv ====
`timescale 1ns/1ns

module tb_rs_alu import rs_pkg::*;;

    localparam int RS_DEPTH   = 16;   // DUT defaults
    localparam int NUM_WAKE   = 4;
    localparam int CLK_PERIOD = 4;
    localparam int N_TRANS    = 25;
    localparam int TIMEOUT_NS = (N_TRANS * 20 + 100) * CLK_PERIOD;

    logic                clk;
    logic                reset;
    logic                disp_req;
    inst_num_t           disp_inst_num;
    pc_t                 disp_pc;
    tag_t                disp_rd;
    alu_op_t             disp_alu_op;
    logic                disp_src1_sel;
    logic                disp_src2_sel;
    imm_t                disp_imm;
    tag_t                disp_src1_tag;
    tag_t                disp_src2_tag;
    logic                disp_src1_ready;
    logic                disp_src2_ready;
    logic [NUM_WAKE-1:0] wake_valid;
    tag_t [NUM_WAKE-1:0] wake_tag;
    logic                disp_ack;
    logic                issue_valid;
    inst_num_t           issue_inst_num;
    pc_t                 issue_pc;
    tag_t                issue_rd;
    alu_op_t             issue_alu_op;
    logic                issue_src1_sel;
    logic                issue_src2_sel;
    imm_t                issue_imm;
    tag_t                issue_src1_tag;
    tag_t                issue_src2_tag;

    integer  seed;
    int      next_id;
    int      issue_count;
    // expected payload per dispatched instruction, indexed by inst_num
    pc_t     exp_pc   [32];
    tag_t    exp_rd   [32];
    alu_op_t exp_op   [32];
    logic    exp_sel1 [32];
    logic    exp_sel2 [32];
    imm_t    exp_imm  [32];
    tag_t    exp_tag1 [32];
    tag_t    exp_tag2 [32];

    rs_alu i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        if (issue_valid === 1'b1)
            issue_count++;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the DUT stopped answering dispatch or issue");
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic report_mismatch(string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_tag(tag_t got, tag_t exp, string what);
        if (got !== exp)
            report_mismatch($sformatf("%s is %0h, expected %0h", what, got, exp));
    endtask

    task automatic check_inst_num(inst_num_t got, inst_num_t exp, string what);
        if (got !== exp)
            report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_word(pc_t got, pc_t exp, string what);
        if (got !== exp)
            report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_op(alu_op_t got, alu_op_t exp, string what);
        if (got !== exp)
            report_mismatch($sformatf("%s is %0h, expected %0h", what, got, exp));
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp)
            report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic expect_count(int exp, string what);
        if (issue_count != exp)
            report_mismatch($sformatf("%s: %0d issues, expected %0d", what, issue_count, exp));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic expect_issue(int id);
        check_bit(issue_valid, 1'b1, "issue_valid");
        check_inst_num(issue_inst_num, inst_num_t'(id), "issue_inst_num");
        check_word(issue_pc, exp_pc[id], "issue_pc");
        check_tag(issue_rd, exp_rd[id], "issue_rd");
        check_op(issue_alu_op, exp_op[id], "issue_alu_op");
        check_bit(issue_src1_sel, exp_sel1[id], "issue_src1_sel");
        check_bit(issue_src2_sel, exp_sel2[id], "issue_src2_sel");
        check_word(issue_imm, exp_imm[id], "issue_imm");
        check_tag(issue_src1_tag, exp_tag1[id], "issue_src1_tag");
        check_tag(issue_src2_tag, exp_tag2[id], "issue_src2_tag");
    endtask

    // one full four-phase exchange; returns one cycle after ack rose
    task automatic dispatch(input tag_t src1_tag, input logic src1_ready,
                            input logic bypass, output int id);
        id              = next_id;
        disp_inst_num   = inst_num_t'(id);
        disp_pc         = pc_t'($random(seed));
        disp_rd         = tag_t'($random(seed));
        disp_alu_op     = alu_op_t'($random(seed));
        disp_src1_sel   = 1'($random(seed));
        disp_src2_sel   = 1'($random(seed));
        disp_imm        = imm_t'($random(seed));
        disp_src1_tag   = src1_tag;
        disp_src2_tag   = tag_t'($random(seed));
        disp_src1_ready = src1_ready;
        disp_src2_ready = 1'b1;
        exp_pc[id]   = disp_pc;
        exp_rd[id]   = disp_rd;
        exp_op[id]   = disp_alu_op;
        exp_sel1[id] = disp_src1_sel;
        exp_sel2[id] = disp_src2_sel;
        exp_imm[id]  = disp_imm;
        exp_tag1[id] = src1_tag;
        exp_tag2[id] = disp_src2_tag;
        next_id++;
        disp_req = 1'b1;
        if (bypass) begin
            wake_valid[0] = 1'b1;   // broadcast lands on the allocation edge
            wake_tag[0]   = src1_tag;
        end
        next_cycle();
        while (!disp_ack)
            next_cycle();
        wake_valid = '0;
        disp_req   = 1'b0;
        next_cycle();
        check_bit(disp_ack, 1'b0, "disp_ack after req dropped");
    endtask

    task automatic broadcast(int port, tag_t tag);
        wake_valid[port] = 1'b1;
        wake_tag[port]   = tag;
        next_cycle();
        wake_valid = '0;
    endtask

    task automatic issue_when_ready();
        int id;
        check_bit(disp_ack, 1'b0, "disp_ack after reset");
        check_bit(issue_valid, 1'b0, "issue_valid after reset");
        dispatch(8'h11, 1'b1, 1'b0, id);
        expect_issue(id);
        next_cycle();
        check_bit(issue_valid, 1'b0, "issue_valid second cycle");
        expect_count(1, "ready dispatch");
    endtask

    task automatic wake_each_port();
        int id;
        for (int w = 0; w < NUM_WAKE; w++) begin
            dispatch(tag_t'(8'h20 + w), 1'b0, 1'b0, id);
            repeat (2) begin
                check_bit(issue_valid, 1'b0, "issue_valid while waiting");
                next_cycle();
            end
            broadcast(w, tag_t'(8'h20 + w));
            check_bit(issue_valid, 1'b0, "issue_valid on wakeup edge");
            next_cycle();
            expect_issue(id);
            next_cycle();
        end
        expect_count(5, "wakeup per port");
    endtask

    task automatic pass_older_entry();
        int old_id;
        int young_id;
        dispatch(8'h30, 1'b0, 1'b0, old_id);
        dispatch(8'h31, 1'b1, 1'b0, young_id);
        expect_issue(young_id);   // younger one overtakes
        repeat (3) begin
            next_cycle();
            check_bit(issue_valid, 1'b0, "issue_valid before older wakes");
        end
        broadcast(1, 8'h30);
        next_cycle();
        expect_issue(old_id);
        repeat (3) begin
            next_cycle();
            check_bit(issue_valid, 1'b0, "issue_valid after both issued");
        end
        expect_count(7, "out of order pair");
    endtask

    task automatic bypass_on_alloc();
        int id;
        dispatch(8'h44, 1'b0, 1'b1, id);
        expect_issue(id);
        next_cycle();
        check_bit(issue_valid, 1'b0, "issue_valid after bypass issue");
        expect_count(8, "dispatch bypass");
    endtask

    task automatic fill_and_stall();
        int first_id;
        int id;
        int last_id;
        repeat (RS_DEPTH) next_cycle();   // head catches up with tail
        for (int k = 0; k < RS_DEPTH; k++) begin
            dispatch(tag_t'(8'h50 + k), 1'b0, 1'b0, id);
            if (k == 0)
                first_id = id;
        end
        fork
            dispatch(8'h99, 1'b1, 1'b0, last_id);
            begin
                repeat (4) begin
                    next_cycle();
                    check_bit(disp_ack, 1'b0, "disp_ack while full");
                end
                broadcast(2, 8'h50);
                next_cycle();
                expect_issue(first_id);
            end
        join
        for (int k = 1; k < RS_DEPTH; k++)
            broadcast(k % NUM_WAKE, tag_t'(8'h50 + k));
        repeat (3 * RS_DEPTH) next_cycle();
        expect_count(25, "full buffer drain");
        check_bit(issue_valid, 1'b0, "issue_valid after drain");
    endtask

    initial begin
        seed            = 32'hdb460472;
        next_id         = 0;
        issue_count     = 0;
        reset           = 1'b1;
        disp_req        = 1'b0;
        disp_inst_num   = '0;
        disp_pc         = '0;
        disp_rd         = '0;
        disp_alu_op     = '0;
        disp_src1_sel   = 1'b0;
        disp_src2_sel   = 1'b0;
        disp_imm        = '0;
        disp_src1_tag   = '0;
        disp_src2_tag   = '0;
        disp_src1_ready = 1'b0;
        disp_src2_ready = 1'b0;
        wake_valid      = '0;
        wake_tag        = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        issue_when_ready();
        wake_each_port();
        pass_older_entry();
        bypass_on_alloc();
        fill_and_stall();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== verilog/rs_alu.sv ====
`timescale 1ns/1ns

module rs_alu import rs_pkg::*; #(
    parameter int RS_DEPTH     = 16,
    parameter int ISSUE_WINDOW = 8,
    parameter int NUM_WAKE     = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                disp_req,
    input  inst_num_t           disp_inst_num,
    input  pc_t                 disp_pc,
    input  tag_t                disp_rd,
    input  alu_op_t             disp_alu_op,
    input  logic                disp_src1_sel,
    input  logic                disp_src2_sel,
    input  imm_t                disp_imm,
    input  tag_t                disp_src1_tag,
    input  tag_t                disp_src2_tag,
    input  logic                disp_src1_ready,
    input  logic                disp_src2_ready,
    input  logic [NUM_WAKE-1:0] wake_valid,
    input  tag_t [NUM_WAKE-1:0] wake_tag,
    output logic                disp_ack,
    output logic                issue_valid,
    output inst_num_t           issue_inst_num,
    output pc_t                 issue_pc,
    output tag_t                issue_rd,
    output alu_op_t             issue_alu_op,
    output logic                issue_src1_sel,
    output logic                issue_src2_sel,
    output imm_t                issue_imm,
    output tag_t                issue_src1_tag,
    output tag_t                issue_src2_tag
);

    localparam int IDX_W = $clog2(RS_DEPTH);

    logic [RS_DEPTH-1:0] busy;
    logic [RS_DEPTH-1:0] ready;
    logic                alloc_en;
    logic [IDX_W-1:0]    alloc_idx;
    logic [IDX_W-1:0]    head_idx;
    logic                issue_en;
    logic [IDX_W-1:0]    issue_idx;

    // entry fields read out at issue_idx
    inst_num_t           rd_inst_num;
    pc_t                 rd_pc;
    tag_t                rd_rd;
    alu_op_t             rd_alu_op;
    logic                rd_src1_sel;
    logic                rd_src2_sel;
    imm_t                rd_imm;
    tag_t                rd_src1_tag;
    tag_t                rd_src2_tag;

    rs_queue_ctrl #(
        .RS_DEPTH     (RS_DEPTH)
    ) i_queue_ctrl (.*);

    rs_entry_table #(
        .RS_DEPTH     (RS_DEPTH),
        .NUM_WAKE     (NUM_WAKE)
    ) i_entry_table (.*);

    rs_issue_select #(
        .RS_DEPTH     (RS_DEPTH),
        .ISSUE_WINDOW (ISSUE_WINDOW)
    ) i_issue_select (.*);

endmodule

// ==== verilog/rs_entry_table.sv ====
`timescale 1ns/1ns

module rs_entry_table import rs_pkg::*; #(
    parameter int  RS_DEPTH = 16,
    parameter int  NUM_WAKE = 4,
    localparam int IDX_W    = $clog2(RS_DEPTH)
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                alloc_en,
    input  logic [IDX_W-1:0]    alloc_idx,
    input  inst_num_t           disp_inst_num,
    input  pc_t                 disp_pc,
    input  tag_t                disp_rd,
    input  alu_op_t             disp_alu_op,
    input  logic                disp_src1_sel,
    input  logic                disp_src2_sel,
    input  imm_t                disp_imm,
    input  tag_t                disp_src1_tag,
    input  tag_t                disp_src2_tag,
    input  logic                disp_src1_ready,
    input  logic                disp_src2_ready,
    input  logic [NUM_WAKE-1:0] wake_valid,
    input  tag_t [NUM_WAKE-1:0] wake_tag,
    input  logic                issue_en,
    input  logic [IDX_W-1:0]    issue_idx,
    output logic [RS_DEPTH-1:0] busy,
    output logic [RS_DEPTH-1:0] ready,
    output inst_num_t           rd_inst_num,
    output pc_t                 rd_pc,
    output tag_t                rd_rd,
    output alu_op_t             rd_alu_op,
    output logic                rd_src1_sel,
    output logic                rd_src2_sel,
    output imm_t                rd_imm,
    output tag_t                rd_src1_tag,
    output tag_t                rd_src2_tag
);

    inst_num_t           inst_num_q [RS_DEPTH];
    pc_t                 pc_q       [RS_DEPTH];
    tag_t                rd_q       [RS_DEPTH];
    alu_op_t             alu_op_q   [RS_DEPTH];
    imm_t                imm_q      [RS_DEPTH];
    tag_t                src1_tag_q [RS_DEPTH];
    tag_t                src2_tag_q [RS_DEPTH];
    logic [RS_DEPTH-1:0] src1_sel_q;
    logic [RS_DEPTH-1:0] src2_sel_q;
    logic [RS_DEPTH-1:0] src1_rdy;
    logic [RS_DEPTH-1:0] src2_rdy;
    logic [RS_DEPTH-1:0] hit1;
    logic [RS_DEPTH-1:0] hit2;
    logic                alloc_hit1;
    logic                alloc_hit2;

    // tag compare of every stored operand, and the incoming one, against all result buses
    always_comb begin
        hit1       = '0;
        hit2       = '0;
        alloc_hit1 = 1'b0;
        alloc_hit2 = 1'b0;
        for (int w = 0; w < NUM_WAKE; w++) begin
            if (wake_valid[w]) begin
                for (int i = 0; i < RS_DEPTH; i++) begin
                    if (src1_tag_q[i] == wake_tag[w])
                        hit1[i] = 1'b1;
                    if (src2_tag_q[i] == wake_tag[w])
                        hit2[i] = 1'b1;
                end
                if (disp_src1_tag == wake_tag[w])
                    alloc_hit1 = 1'b1;
                if (disp_src2_tag == wake_tag[w])
                    alloc_hit2 = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= '0;
            src1_rdy <= '0;
            src2_rdy <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (busy[i] && !src1_rdy[i] && hit1[i])
                    src1_rdy[i] <= 1'b1;
                if (busy[i] && !src2_rdy[i] && hit2[i])
                    src2_rdy[i] <= 1'b1;
            end
            if (issue_en)
                busy[issue_idx] <= 1'b0;
            if (alloc_en) begin
                busy[alloc_idx]     <= 1'b1;
                src1_rdy[alloc_idx] <= disp_src1_ready | alloc_hit1;  // dispatch bypass
                src2_rdy[alloc_idx] <= disp_src2_ready | alloc_hit2;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            inst_num_q[alloc_idx] <= disp_inst_num;
            pc_q[alloc_idx]       <= disp_pc;
            rd_q[alloc_idx]       <= disp_rd;
            alu_op_q[alloc_idx]   <= disp_alu_op;
            src1_sel_q[alloc_idx] <= disp_src1_sel;
            src2_sel_q[alloc_idx] <= disp_src2_sel;
            imm_q[alloc_idx]      <= disp_imm;
            src1_tag_q[alloc_idx] <= disp_src1_tag;
            src2_tag_q[alloc_idx] <= disp_src2_tag;
        end
    end

    assign ready = busy & src1_rdy & src2_rdy;

    assign rd_inst_num = inst_num_q[issue_idx];
    assign rd_pc       = pc_q[issue_idx];
    assign rd_rd       = rd_q[issue_idx];
    assign rd_alu_op   = alu_op_q[issue_idx];
    assign rd_src1_sel = src1_sel_q[issue_idx];
    assign rd_src2_sel = src2_sel_q[issue_idx];
    assign rd_imm      = imm_q[issue_idx];
    assign rd_src1_tag = src1_tag_q[issue_idx];
    assign rd_src2_tag = src2_tag_q[issue_idx];

    a_issue_ready: assert property (@(posedge clk) disable iff (reset)
        issue_en |-> busy[issue_idx] && src1_rdy[issue_idx] && src2_rdy[issue_idx]);

    a_alloc_free: assert property (@(posedge clk) disable iff (reset)
        alloc_en |-> !busy[alloc_idx]);

endmodule

// ==== verilog/rs_issue_select.sv ====
`timescale 1ns/1ns

module rs_issue_select import rs_pkg::*; #(
    parameter int  RS_DEPTH     = 16,
    parameter int  ISSUE_WINDOW = 8,
    localparam int IDX_W        = $clog2(RS_DEPTH)
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [RS_DEPTH-1:0] ready,
    input  logic [IDX_W-1:0]    head_idx,
    input  inst_num_t           rd_inst_num,
    input  pc_t                 rd_pc,
    input  tag_t                rd_rd,
    input  alu_op_t             rd_alu_op,
    input  logic                rd_src1_sel,
    input  logic                rd_src2_sel,
    input  imm_t                rd_imm,
    input  tag_t                rd_src1_tag,
    input  tag_t                rd_src2_tag,
    output logic                issue_en,
    output logic [IDX_W-1:0]    issue_idx,
    output logic                issue_valid,
    output inst_num_t           issue_inst_num,
    output pc_t                 issue_pc,
    output tag_t                issue_rd,
    output alu_op_t             issue_alu_op,
    output logic                issue_src1_sel,
    output logic                issue_src2_sel,
    output imm_t                issue_imm,
    output tag_t                issue_src1_tag,
    output tag_t                issue_src2_tag
);

    // oldest ready entry, scanning from head with wrap-around
    always_comb begin
        logic [IDX_W-1:0] idx;
        idx       = head_idx;
        issue_en  = 1'b0;
        issue_idx = head_idx;
        for (int k = 0; k < ISSUE_WINDOW; k++) begin
            idx = head_idx + IDX_W'(k);
            if (!issue_en && ready[idx]) begin
                issue_en  = 1'b1;
                issue_idx = idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            issue_valid <= 1'b0;
        else
            issue_valid <= issue_en;   // one cycle strobe per issued entry
    end

    always_ff @(posedge clk) begin
        if (issue_en) begin
            issue_inst_num <= rd_inst_num;
            issue_pc       <= rd_pc;
            issue_rd       <= rd_rd;
            issue_alu_op   <= rd_alu_op;
            issue_src1_sel <= rd_src1_sel;
            issue_src2_sel <= rd_src2_sel;
            issue_imm      <= rd_imm;
            issue_src1_tag <= rd_src1_tag;
            issue_src2_tag <= rd_src2_tag;
        end
    end

endmodule

// ==== verilog/rs_pkg.sv ====
package rs_pkg;

    localparam int TAG_W      = 8;
    localparam int INST_NUM_W = 32;
    localparam int PC_W       = 32;
    localparam int ALU_OP_W   = 4;
    localparam int IMM_W      = 32;

    // physical register tag, shared by sources, destination and result buses
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INST_NUM_W-1:0] inst_num_t;   // program order sequence number
    typedef logic [PC_W-1:0]       pc_t;
    typedef logic [ALU_OP_W-1:0]   alu_op_t;
    typedef logic [IMM_W-1:0]      imm_t;

    // four-phase dispatch handshake
    typedef enum logic {
        HS_IDLE = 1'b0,   // waiting for disp_req
        HS_ACK  = 1'b1    // entry written, ack held until req drops
    } hs_state_t;

endpackage

// ==== verilog/rs_queue_ctrl.sv ====
`timescale 1ns/1ns

module rs_queue_ctrl import rs_pkg::*; #(
    parameter int  RS_DEPTH = 16,
    localparam int IDX_W    = $clog2(RS_DEPTH)
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                disp_req,
    input  logic [RS_DEPTH-1:0] busy,
    output logic                disp_ack,
    output logic                alloc_en,
    output logic [IDX_W-1:0]    alloc_idx,
    output logic [IDX_W-1:0]    head_idx
);

    localparam int CNT_W = IDX_W + 1;

    hs_state_t        state;
    logic [IDX_W-1:0] tail;
    logic [IDX_W-1:0] head;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             retire;

    assign full      = (count == CNT_W'(RS_DEPTH));
    assign alloc_en  = (state == HS_IDLE) && disp_req && !full;
    assign alloc_idx = tail;
    assign head_idx  = head;
    assign disp_ack  = (state == HS_ACK);

    // head slot already issued, step past it
    assign retire = (count != '0) && !busy[head];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= HS_IDLE;
        end else begin
            case (state)
                HS_IDLE: begin
                    if (alloc_en)
                        state <= HS_ACK;
                end
                HS_ACK: begin
                    if (!disp_req)
                        state <= HS_IDLE;   // ack falls at this edge
                end
                default: state <= HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tail  <= '0;
            head  <= '0;
            count <= '0;
        end else begin
            if (alloc_en)
                tail <= tail + 1'b1;    // wraps, depth is a power of two
            if (retire)
                head <= head + 1'b1;
            case ({alloc_en, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // pointers meet with entries held, so every slot is taken
    a_no_alloc_when_full: assert property (@(posedge clk) disable iff (reset)
        (tail == head) && (count != '0) |-> !alloc_en);

endmodule
